// ==== Makefile ====
TOP := tb_axi_sram

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f all.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
axi_pkg.sv
mem_pkg.sv
mem_port_if.sv
chan_fifo.sv
axi_write_ctrl.sv
sram_bank.sv
axi_read_ctrl.sv
axi_sram_top.sv
tb_axi_sram.sv

// ==== axi_pkg.sv ====
// bus-side types for the 64-bit AXI slave; every beat is a full 8-byte word
// no ids and no size field, so narrow transfers are not representable
package axi_pkg;

   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = data_w / 8;

   typedef logic [addr_w-1:0] axi_addr_t;
   typedef logic [data_w-1:0] axi_data_t;
   typedef logic [strb_w-1:0] axi_strb_t;
   typedef logic [7:0]        axi_len_t;    // beats minus one

   typedef enum logic [1:0] {
      burst_fixed = 2'b00,
      burst_incr  = 2'b01,
      burst_wrap  = 2'b10
   } axi_burst_t;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_decerr = 2'b11
   } axi_resp_t;

   // AW and AR request, size dropped
   typedef struct packed {
      axi_addr_t  addr;
      axi_len_t   len;
      axi_burst_t burst;
   } axi_ax_t;

   typedef struct packed {
      axi_data_t data;
      axi_strb_t strb;
      logic      last;
   } axi_w_t;

   // address of the following beat; wrap is walked like incr
   function automatic axi_addr_t next_beat_addr(input axi_addr_t addr,
                                                input axi_burst_t burst);
      case (burst)
         burst_fixed:            return addr;
         burst_incr, burst_wrap: return addr + strb_w;
         default:                return addr + strb_w;   // reserved code
      endcase
   endfunction

endpackage

// ==== axi_read_ctrl.sv ====
// read burst walker: bank read per beat into a registered R slot
// one read in flight plus one held beat; next AR may start on the last issue
`timescale 1ns/1ps

module axi_read_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               ar_valid,
   input  axi_pkg::axi_ax_t   ar_data,
   output logic               ar_pop,
   output logic               rvalid,
   output axi_pkg::axi_data_t rdata,
   output axi_pkg::axi_resp_t rresp,
   output logic               rlast,
   input  logic               rready,
   mem_port_if.ctrl           mem
);

   logic                busy;        // burst being walked
   axi_pkg::axi_addr_t  addr;
   axi_pkg::axi_len_t   remain;
   axi_pkg::axi_burst_t burst;
   logic                pend_valid;  // bank rdata holds an uncaptured beat
   logic                pend_err;
   logic                pend_last;
   logic                slot_free;
   logic                issue;
   logic                last_issue;
   logic                capture;

   assign slot_free  = !rvalid || rready;
   assign issue      = busy && slot_free;
   assign last_issue = issue && (remain == '0);
   assign capture    = pend_valid && slot_free;
   assign ar_pop     = ar_valid && (!busy || last_issue);

   // out-of-window beats skip the bank, data is zeroed at capture
   assign mem.en    = issue && mem_pkg::in_window(addr);
   assign mem.we    = 1'b0;
   assign mem.idx   = mem_pkg::word_idx(addr);
   assign mem.wdata = '0;
   assign mem.strb  = '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy       <= 1'b0;
         pend_valid <= 1'b0;
         rvalid     <= 1'b0;
      end else begin
         if (ar_pop)          busy <= 1'b1;
         else if (last_issue) busy <= 1'b0;
         pend_valid <= issue || (pend_valid && !capture);
         if (capture)     rvalid <= 1'b1;
         else if (rready) rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_pop) begin
         addr   <= ar_data.addr;
         remain <= ar_data.len;
         burst  <= ar_data.burst;
      end else if (issue) begin
         addr   <= axi_pkg::next_beat_addr(addr, burst);
         remain <= remain - 1'b1;
      end
      if (issue) begin
         pend_err  <= !mem_pkg::in_window(addr);
         pend_last <= (remain == '0);
      end
      if (capture) begin
         rdata <= pend_err ? '0 : mem.rdata;
         rresp <= pend_err ? axi_pkg::resp_decerr : axi_pkg::resp_okay;
         rlast <= pend_last;
      end
   end

endmodule

// ==== axi_sram_top.sv ====
// AXI4 memory slave over 4 KiB SRAM; size is ignored and wrap runs as incr
// no ids, no exclusive access, no ordering between read and write channels
`timescale 1ns/1ps

module axi_sram_top (
   input  logic                 clk,
   input  logic                 rst,
   input  axi_pkg::axi_addr_t   awaddr,
   input  axi_pkg::axi_len_t    awlen,
   input  logic [2:0]           awsize,
   input  logic [1:0]           awburst,
   input  logic                 awvalid,
   output logic                 awready,
   input  axi_pkg::axi_data_t   wdata,
   input  axi_pkg::axi_strb_t   wstrb,
   input  logic                 wlast,
   input  logic                 wvalid,
   output logic                 wready,
   output axi_pkg::axi_resp_t   bresp,
   output logic                 bvalid,
   input  logic                 bready,
   input  axi_pkg::axi_addr_t   araddr,
   input  axi_pkg::axi_len_t    arlen,
   input  logic [2:0]           arsize,
   input  logic [1:0]           arburst,
   input  logic                 arvalid,
   output logic                 arready,
   output axi_pkg::axi_data_t   rdata,
   output axi_pkg::axi_resp_t   rresp,
   output logic                 rlast,
   output logic                 rvalid,
   input  logic                 rready
);

   axi_pkg::axi_ax_t aw_in, aw_q, ar_in, ar_q;
   axi_pkg::axi_w_t  w_in, w_q;
   logic             aw_q_valid, aw_pop;
   logic             w_q_valid, w_pop;
   logic             ar_q_valid, ar_pop;

   mem_port_if wr_port ();
   mem_port_if rd_port ();

   // size fields stay unconnected
   assign aw_in = '{addr: awaddr, len: awlen, burst: axi_pkg::axi_burst_t'(awburst)};
   assign ar_in = '{addr: araddr, len: arlen, burst: axi_pkg::axi_burst_t'(arburst)};
   assign w_in  = '{data: wdata, strb: wstrb, last: wlast};

   chan_fifo #(.payload_t(axi_pkg::axi_ax_t), .depth(2)) u_aw_fifo (
      .clk(clk), .rst(rst),
      .in_valid(awvalid), .in_data(aw_in), .in_ready(awready),
      .out_valid(aw_q_valid), .out_data(aw_q), .out_ready(aw_pop)
   );

   chan_fifo #(.payload_t(axi_pkg::axi_w_t), .depth(2)) u_w_fifo (
      .clk(clk), .rst(rst),
      .in_valid(wvalid), .in_data(w_in), .in_ready(wready),
      .out_valid(w_q_valid), .out_data(w_q), .out_ready(w_pop)
   );

   chan_fifo #(.payload_t(axi_pkg::axi_ax_t), .depth(2)) u_ar_fifo (
      .clk(clk), .rst(rst),
      .in_valid(arvalid), .in_data(ar_in), .in_ready(arready),
      .out_valid(ar_q_valid), .out_data(ar_q), .out_ready(ar_pop)
   );

   axi_write_ctrl u_write_ctrl (
      .clk(clk), .rst(rst),
      .aw_valid(aw_q_valid), .aw_data(aw_q), .aw_pop(aw_pop),
      .w_valid(w_q_valid), .w_data(w_q), .w_pop(w_pop),
      .bvalid(bvalid), .bresp(bresp), .bready(bready),
      .mem(wr_port)
   );

   axi_read_ctrl u_read_ctrl (
      .clk(clk), .rst(rst),
      .ar_valid(ar_q_valid), .ar_data(ar_q), .ar_pop(ar_pop),
      .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rlast(rlast),
      .rready(rready),
      .mem(rd_port)
   );

   sram_bank u_bank (
      .clk(clk),
      .wr(wr_port),
      .rd(rd_port)
   );

endmodule

// ==== axi_write_ctrl.sv ====
// write burst walker: one AW, then len+1 W beats, then one B response
// beat count comes from len only; wlast is carried but never trusted
`timescale 1ns/1ps

module axi_write_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  logic               aw_valid,
   input  axi_pkg::axi_ax_t   aw_data,
   output logic               aw_pop,
   input  logic               w_valid,
   input  axi_pkg::axi_w_t    w_data,
   output logic               w_pop,
   output logic               bvalid,
   output axi_pkg::axi_resp_t bresp,
   input  logic               bready,
   mem_port_if.ctrl           mem
);

   typedef enum logic [1:0] {
      st_idle,
      st_data,
      st_resp
   } state_t;

   state_t              state;
   axi_pkg::axi_addr_t  addr;     // address of the next beat
   axi_pkg::axi_len_t   remain;   // beats left after the current one
   axi_pkg::axi_burst_t burst;
   logic                err;      // sticky over the burst
   logic                in_win;

   assign in_win = mem_pkg::in_window(addr);

   // AW is only taken once the previous B has gone
   assign aw_pop = (state == st_idle) && aw_valid;
   assign w_pop  = (state == st_data) && w_valid;

   assign bvalid = (state == st_resp);
   assign bresp  = err ? axi_pkg::resp_decerr : axi_pkg::resp_okay;

   // write lands on the edge of the popping cycle
   assign mem.en    = w_pop && in_win;
   assign mem.we    = mem.en;
   assign mem.idx   = mem_pkg::word_idx(addr);
   assign mem.wdata = w_data.data;
   assign mem.strb  = w_data.strb;

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_idle;
         err   <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (aw_valid) begin
                  state <= st_data;
                  err   <= 1'b0;
               end
            end
            st_data: begin
               if (w_valid) begin
                  if (!in_win) err <= 1'b1;          // beat dropped
                  if (remain == '0) state <= st_resp;
               end
            end
            st_resp: begin
               if (bready) state <= st_idle;
            end
            default: state <= st_idle;
         endcase
      end
   end

   // burst walk
   always_ff @(posedge clk) begin
      if (aw_pop) begin
         addr   <= aw_data.addr;
         remain <= aw_data.len;
         burst  <= aw_data.burst;
      end else if (w_pop) begin
         addr   <= axi_pkg::next_beat_addr(addr, burst);
         remain <= remain - 1'b1;
      end
   end

endmodule

// ==== chan_fifo.sv ====
// valid/ready queue for one AXI channel, registered output, no bypass
// a full queue still takes a push in the cycle it is popped
`timescale 1ns/1ps

module chan_fifo #(
   parameter type payload_t = logic,
   parameter int  depth     = 2
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
   localparam int cnt_w = $clog2(depth + 1);

   payload_t         slots [depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   assign out_valid = (count != '0);
   assign out_data  = slots[rd_ptr];
   assign pop       = out_valid && out_ready;
   assign in_ready  = (count != cnt_w'(depth)) || pop;
   assign push      = in_valid && in_ready;

   always_ff @(posedge clk) begin
      if (push) slots[wr_ptr] <= in_data;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)  rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         count <= count + cnt_w'(push) - cnt_w'(pop);
      end
   end

endmodule

// ==== mem_pkg.sv ====
// 4 KiB on-chip window at 0x8000_0000, word addressed, 8 bytes per word
// low three address bits are dropped, unaligned beats hit the containing word
package mem_pkg;

   localparam int mem_words = 512;
   localparam int mem_aw    = $clog2(mem_words);
   localparam int byte_off  = 3;                      // log2 of bytes per word
   localparam axi_pkg::axi_addr_t mem_base = 32'h8000_0000;

   typedef logic [mem_aw-1:0] mem_idx_t;

   function automatic logic in_window(input axi_pkg::axi_addr_t addr);
      axi_pkg::axi_addr_t off;
      off = addr - mem_base;   // below base wraps to a huge offset
      return off < (mem_words << byte_off);
   endfunction

   function automatic mem_idx_t word_idx(input axi_pkg::axi_addr_t addr);
      return addr[byte_off +: mem_aw];
   endfunction

endpackage

// ==== mem_port_if.sv ====
// one SRAM port between a burst controller and the bank
// rdata is registered in the bank and valid the cycle after en
`timescale 1ns/1ps

interface mem_port_if;

   logic                 en;
   logic                 we;      // low on the read port
   mem_pkg::mem_idx_t    idx;
   axi_pkg::axi_data_t   wdata;
   axi_pkg::axi_strb_t   strb;    // byte lanes to merge on write
   axi_pkg::axi_data_t   rdata;

   modport ctrl (
      output en,
      output we,
      output idx,
      output wdata,
      output strb,
      input  rdata
   );

   modport bank (
      input  en,
      input  we,
      input  idx,
      input  wdata,
      input  strb,
      output rdata
   );

endinterface

// ==== sram_bank.sv ====
// byte-enabled word storage, one write port and one registered read port
// contents are not cleared; same-word read and write returns the old word
`timescale 1ns/1ps

module sram_bank (
   input logic      clk,
   mem_port_if.bank wr,
   mem_port_if.bank rd
);

   axi_pkg::axi_data_t mem [mem_pkg::mem_words];

   // merge under the strobe
   always_ff @(posedge clk) begin
      if (wr.en && wr.we) begin
         for (int b = 0; b < axi_pkg::strb_w; b++) begin
            if (wr.strb[b]) mem[wr.idx][8*b +: 8] <= wr.wdata[8*b +: 8];
         end
      end
   end

   // rdata holds until the next read
   always_ff @(posedge clk) begin
      if (rd.en && !rd.we) rd.rdata <= mem[rd.idx];
   end

   assign wr.rdata = '0;   // write-only port

endmodule

// ==== tb_axi_sram.sv ====
// directed tests for the AXI SRAM slave against a reference memory
// words are preset with full-strobe writes before any read as contents start unknown
`timescale 1ns/1ps

module tb_axi_sram;

   localparam int total_beats = 94;                  // all W and R beats of the tests
   localparam int max_cycles  = total_beats * 4 + 200;
   localparam axi_pkg::axi_addr_t base = mem_pkg::mem_base;

   logic clk;
   logic rst;
   axi_pkg::axi_addr_t awaddr, araddr;
   axi_pkg::axi_len_t  awlen, arlen;
   logic [2:0]         awsize, arsize;
   logic [1:0]         awburst, arburst;
   logic               awvalid, awready, arvalid, arready;
   axi_pkg::axi_data_t wdata, rdata;
   axi_pkg::axi_strb_t wstrb;
   logic               wlast, wvalid, wready;
   axi_pkg::axi_resp_t bresp, rresp;
   logic               bvalid, bready, rlast, rvalid, rready;

   axi_pkg::axi_data_t ref_mem [mem_pkg::mem_words];
   logic [31:0]        lcg_state;
   int                 errors;
   int                 checks;
   int                 cycles;

   axi_sram_top dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // 4 KiB window above the base in 8-byte words
   function automatic bit inside_window(input axi_pkg::axi_addr_t a);
      return (a >= base) && (a < base + 32'(mem_pkg::mem_words * 8));
   endfunction

   function automatic mem_pkg::mem_idx_t word_index(input axi_pkg::axi_addr_t a);
      return mem_pkg::mem_idx_t'((a - base) >> 3);
   endfunction

   function automatic axi_pkg::axi_addr_t step_addr(input axi_pkg::axi_addr_t a,
                                                    input axi_pkg::axi_burst_t burst);
      return (burst == axi_pkg::burst_fixed) ? a : a + 32'd8;
   endfunction

   task automatic check_data(input axi_pkg::axi_data_t got, input axi_pkg::axi_data_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(input axi_pkg::axi_resp_t got, input axi_pkg::axi_resp_t exp,
                             input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_last(input bit got, input bit exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s: got %b expected %b", $time, what, got, exp);
      end
   endtask

   // all drive tasks start and end 1 ns after a rising edge
   task automatic write_burst(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_len_t len,
                              input axi_pkg::axi_burst_t burst, input bit full_strb,
                              input bit stall);
      axi_pkg::axi_addr_t a;
      axi_pkg::axi_resp_t exp_resp;
      axi_pkg::axi_data_t d;
      axi_pkg::axi_strb_t s;
      logic [31:0]        r;
      bit                 done;
      a = addr;
      exp_resp = axi_pkg::resp_okay;
      awaddr = addr;
      awlen = len;
      awburst = burst;
      awvalid = 1'b1;
      @(negedge clk);
      while (!awready) @(negedge clk);
      @(posedge clk);
      #1;
      awvalid = 1'b0;
      for (int i = 0; i <= int'(len); i++) begin
         r = lcg_next();
         s = full_strb ? '1 : r[23:16];
         d = {lcg_next(), lcg_next()};
         if (inside_window(a)) begin
            for (int b = 0; b < 8; b++)
               if (s[b]) ref_mem[word_index(a)][8*b +: 8] = d[8*b +: 8];
         end else begin
            exp_resp = axi_pkg::resp_decerr;   // beat dropped
         end
         wdata = d;
         wstrb = s;
         wlast = (i == int'(len));
         wvalid = 1'b1;
         @(negedge clk);
         while (!wready) @(negedge clk);
         @(posedge clk);
         #1;
         a = step_addr(a, burst);
      end
      wvalid = 1'b0;
      wlast = 1'b0;
      done = 1'b0;
      while (!done) begin
         r = lcg_next();
         bready = stall ? r[20] : 1'b1;
         @(negedge clk);
         if (bvalid && bready) begin
            check_resp(bresp, exp_resp, "bresp");
            done = 1'b1;
         end
         @(posedge clk);
         #1;
      end
      bready = 1'b0;
   endtask

   task automatic send_ar(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_len_t len,
                          input axi_pkg::axi_burst_t burst);
      araddr = addr;
      arlen = len;
      arburst = burst;
      arvalid = 1'b1;
      @(negedge clk);
      while (!arready) @(negedge clk);
      @(posedge clk);
      #1;
      arvalid = 1'b0;
   endtask

   task automatic collect_r(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_len_t len,
                            input axi_pkg::axi_burst_t burst, input bit stall);
      axi_pkg::axi_addr_t a;
      axi_pkg::axi_data_t exp_data;
      axi_pkg::axi_resp_t exp_resp;
      logic [31:0]        r;
      bit                 done;
      a = addr;
      for (int i = 0; i <= int'(len); i++) begin
         exp_data = inside_window(a) ? ref_mem[word_index(a)] : '0;
         exp_resp = inside_window(a) ? axi_pkg::resp_okay : axi_pkg::resp_decerr;
         done = 1'b0;
         while (!done) begin
            r = lcg_next();
            rready = stall ? r[20] : 1'b1;
            @(negedge clk);
            if (rvalid && rready) begin
               check_data(rdata, exp_data, $sformatf("rdata at %h beat %0d", a, i));
               check_resp(rresp, exp_resp, $sformatf("rresp at %h beat %0d", a, i));
               check_last(rlast, i == int'(len), $sformatf("rlast beat %0d", i));
               done = 1'b1;
            end
            @(posedge clk);
            #1;
         end
         a = step_addr(a, burst);
      end
      rready = 1'b0;
   endtask

   task automatic read_burst(input axi_pkg::axi_addr_t addr, input axi_pkg::axi_len_t len,
                             input axi_pkg::axi_burst_t burst, input bit stall);
      send_ar(addr, len, burst);
      collect_r(addr, len, burst, stall);
   endtask

   task automatic single_beat_rw();
      write_burst(base, 8'd0, axi_pkg::burst_incr, 1'b1, 1'b0);
      read_burst(base, 8'd0, axi_pkg::burst_incr, 1'b0);
   endtask

   task automatic incr_strobe_burst();
      write_burst(base + 32'h40, 8'd7, axi_pkg::burst_incr, 1'b1, 1'b0);   // preset
      write_burst(base + 32'h40, 8'd7, axi_pkg::burst_incr, 1'b0, 1'b0);
      read_burst(base + 32'h40, 8'd7, axi_pkg::burst_incr, 1'b0);
   endtask

   task automatic fixed_burst_merge();
      write_burst(base + 32'h200, 8'd0, axi_pkg::burst_incr, 1'b1, 1'b0);
      write_burst(base + 32'h200, 8'd3, axi_pkg::burst_fixed, 1'b0, 1'b0);
      read_burst(base + 32'h200, 8'd2, axi_pkg::burst_fixed, 1'b0);
   endtask

   task automatic stalled_bursts();
      write_burst(base + 32'h100, 8'd15, axi_pkg::burst_incr, 1'b1, 1'b1);
      read_burst(base + 32'h100, 8'd15, axi_pkg::burst_incr, 1'b1);
   endtask

   // requests queue up while rready is low
   task automatic queued_reads();
      send_ar(base + 32'h100, 8'd3, axi_pkg::burst_incr);
      send_ar(base + 32'h140, 8'd1, axi_pkg::burst_incr);
      send_ar(base + 32'h108, 8'd5, axi_pkg::burst_incr);
      collect_r(base + 32'h100, 8'd3, axi_pkg::burst_incr, 1'b0);
      collect_r(base + 32'h140, 8'd1, axi_pkg::burst_incr, 1'b0);
      collect_r(base + 32'h108, 8'd5, axi_pkg::burst_incr, 1'b0);
   endtask

   // 0xFC0 shares its low index bits with base - 0x40
   task automatic out_of_window_access();
      write_burst(base + 32'hFC0, 8'd3, axi_pkg::burst_incr, 1'b1, 1'b0);
      write_burst(base - 32'h40, 8'd3, axi_pkg::burst_incr, 1'b1, 1'b0);
      read_burst(base - 32'h40, 8'd3, axi_pkg::burst_incr, 1'b0);
      read_burst(base + 32'hFC0, 8'd3, axi_pkg::burst_incr, 1'b0);
   endtask

   initial begin
      cycles = 0;
      while (cycles < max_cycles) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: DUT hung after %0d cycles with %0d errors", cycles, errors);
      $display("sim failed");
      $finish;
   end

   initial begin
      lcg_state = 32'd52;
      errors = 0;
      checks = 0;
      rst = 1'b1;
      awaddr = '0;
      awlen = '0;
      awsize = 3'd3;    // 8-byte beats
      awburst = 2'b01;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wlast = 1'b0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arlen = '0;
      arsize = 3'd3;
      arburst = 2'b01;
      arvalid = 1'b0;
      rready = 1'b0;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;
      single_beat_rw();
      incr_strobe_burst();
      fixed_burst_merge();
      stalled_bursts();
      queued_reads();
      out_of_window_access();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
